// File: rtl/lcd_pkg.sv
/* Shared constants, ST7735S init table and data types for the LCD
   framebuffer SPI driver */
package lcd_pkg;

    localparam int AXI_ADDR_BITS = 32;
    localparam int AXI_DATA_BITS = 32;

    localparam int INIT_LEN = 76;
    localparam int WIN_LEN  = 11;            // CASET, RASET, RAMWR with args
    localparam int SEQ_LEN  = INIT_LEN + WIN_LEN;

    localparam logic [7:0] CMD_SLPOUT = 8'h11;
    localparam logic [7:0] CMD_CASET  = 8'h2A;
    localparam logic [7:0] CMD_RASET  = 8'h2B;
    localparam logic [7:0] CMD_RAMWR  = 8'h2C;

    localparam int WIN_X_START = 1;          // Panel column offset
    localparam int WIN_Y_START = 26;         // Panel row offset

    typedef logic [AXI_ADDR_BITS-1:0] fb_addr_t;
    typedef logic [6:0]               seq_idx_t;
    typedef logic [15:0]              rgb565_t;

    typedef struct packed {
        logic       is_data;                 // Level for the dc pin
        logic [7:0] data;
    } lcd_byte_t;

    // One AXI word, seen as pixels or as bytes. Pixel 0 sits in the low half
    typedef union packed {
        rgb565_t [AXI_DATA_BITS/16-1:0]   pix;
        logic [AXI_DATA_BITS/8-1:0][7:0] bytes;
    } fb_word_u;

    // -----------------------------
    // Power-on table, {is_data, byte}
    // -----------------------------
    localparam lcd_byte_t INIT_TABLE [INIT_LEN] = '{
        9'h011, 9'h021, 9'h021, 9'h0B1, 9'h105, 9'h13A, 9'h13A, 9'h0B2,
        9'h105, 9'h13A, 9'h13A, 9'h0B3, 9'h105, 9'h13A, 9'h13A, 9'h105,
        9'h13A, 9'h13A, 9'h0B4, 9'h103, 9'h0C0, 9'h162, 9'h102, 9'h104,
        9'h0C1, 9'h1C0, 9'h0C2, 9'h10D, 9'h100, 9'h0C3, 9'h18D, 9'h16A,
        9'h0C4, 9'h18D, 9'h1EE, 9'h0C5, 9'h10E, 9'h0E0, 9'h110, 9'h10E,
        9'h102, 9'h103, 9'h10E, 9'h107, 9'h102, 9'h107, 9'h10A, 9'h112,
        9'h127, 9'h137, 9'h100, 9'h10D, 9'h10E, 9'h110, 9'h0E1, 9'h110,
        9'h10E, 9'h103, 9'h103, 9'h10F, 9'h106, 9'h102, 9'h108, 9'h10A,
        9'h113, 9'h126, 9'h136, 9'h100, 9'h10D, 9'h10E, 9'h110, 9'h03A,
        9'h105, 9'h036, 9'h1A8, 9'h029
    };

endpackage

// File: rtl/lcd_seq_rom.sv
/* Command ROM. Init table entries, followed by the CASET/RASET/RAMWR window setup */
module lcd_seq_rom #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 80
) (
    input  lcd_pkg::seq_idx_t  seq_idx,
    output lcd_pkg::lcd_byte_t seq_byte
);
    import lcd_pkg::*;

    localparam logic [15:0] X_END = 16'(FB_WIDTH);
    localparam logic [15:0] Y_END = 16'(FB_HEIGHT + WIN_Y_START - 1);

    always_comb begin
        seq_byte = '{is_data: 1'b0, data: 8'h00};
        if (seq_idx < seq_idx_t'(INIT_LEN)) begin
            seq_byte = INIT_TABLE[seq_idx];
        end else if (seq_idx < seq_idx_t'(SEQ_LEN)) begin
            case (int'(seq_idx) - INIT_LEN)
                0:  seq_byte = '{1'b0, CMD_CASET};
                1:  seq_byte = '{1'b1, 8'h00};
                2:  seq_byte = '{1'b1, 8'(WIN_X_START)};
                3:  seq_byte = '{1'b1, X_END[15:8]};
                4:  seq_byte = '{1'b1, X_END[7:0]};
                5:  seq_byte = '{1'b0, CMD_RASET};
                6:  seq_byte = '{1'b1, 8'h00};
                7:  seq_byte = '{1'b1, 8'(WIN_Y_START)};
                8:  seq_byte = '{1'b1, Y_END[15:8]};
                9:  seq_byte = '{1'b1, Y_END[7:0]};
                default: seq_byte = '{1'b0, CMD_RAMWR};
            endcase
        end
    end

endmodule

// File: rtl/spi_byte_tx.sv
/* SPI mode-0 byte transmitter, MSB first, with clock divider and dc line */
module spi_byte_tx #(
    parameter int CLK_HZ = 50_000_000,
    parameter int SPI_HZ = 12_000_000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tx_start,
    input  lcd_pkg::lcd_byte_t tx_byte,
    output logic               tx_busy,
    output logic               lcd_sclk,
    output logic               lcd_mosi,
    output logic               lcd_dc
);
    localparam int DIV_RAW = CLK_HZ / (2 * SPI_HZ);
    localparam int SPI_DIV = (DIV_RAW < 1) ? 1 : DIV_RAW;
    localparam int DIV_W   = (SPI_DIV <= 1) ? 1 : $clog2(SPI_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [7:0]       shift_q;
    logic [2:0]       bit_cnt;

    assign lcd_mosi = shift_q[7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= 3'd0;
            shift_q  <= 8'h00;
            lcd_sclk <= 1'b0;
            lcd_dc   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                shift_q <= tx_byte.data;
                lcd_dc  <= tx_byte.is_data;   // Held until the next byte
                bit_cnt <= 3'd7;
            end
        end else if (div_cnt == DIV_W'(SPI_DIV - 1)) begin
            div_cnt  <= '0;
            lcd_sclk <= ~lcd_sclk;
            if (lcd_sclk) begin                // Falling edge
                shift_q <= {shift_q[6:0], 1'b0};
                bit_cnt <= bit_cnt - 3'd1;
                if (bit_cnt == 3'd0) begin
                    tx_busy <= 1'b0;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// File: rtl/fb_reader.sv
/* Framebuffer reader. Single-beat AXI4 reads, one word held until taken */
module fb_reader #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 80
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                frame_begin,
    input  lcd_pkg::fb_addr_t                   fb_base,
    input  logic                                word_taken,
    input  logic                                m_axi_arready,
    input  logic [lcd_pkg::AXI_DATA_BITS-1:0]   m_axi_rdata,
    input  logic                                m_axi_rvalid,
    output lcd_pkg::fb_word_u                   word,
    output logic                                word_valid,
    output logic                                fetch_done,
    output lcd_pkg::fb_addr_t                   m_axi_araddr,
    output logic [7:0]                          m_axi_arlen,
    output logic [2:0]                          m_axi_arsize,
    output logic [1:0]                          m_axi_arburst,
    output logic                                m_axi_arvalid,
    output logic                                m_axi_rready
);
    localparam int FB_WORDS = FB_WIDTH * FB_HEIGHT / 2;
    localparam int CNT_W    = $clog2(FB_WORDS + 1);

    logic [CNT_W-1:0] word_idx;          // Words requested so far

    assign m_axi_arlen   = 8'd0;
    assign m_axi_arsize  = 3'd2;         // 4 bytes
    assign m_axi_arburst = 2'b01;        // INCR
    assign fetch_done    = (word_idx == CNT_W'(FB_WORDS)) && !m_axi_rready && !word_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx      <= CNT_W'(FB_WORDS);   // Idle counts as done
            m_axi_araddr  <= '0;
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            word_valid    <= 1'b0;
        end else begin
            if (frame_begin) begin
                word_idx     <= '0;
                m_axi_araddr <= fb_base;
            end else if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
                m_axi_rready  <= 1'b1;
                word_idx      <= word_idx + 1'b1;
                m_axi_araddr  <= m_axi_araddr + 32'd4;
            end else if (!m_axi_arvalid && !m_axi_rready && !word_valid &&
                         word_idx < CNT_W'(FB_WORDS)) begin
                m_axi_arvalid <= 1'b1;
            end

            if (m_axi_rready && m_axi_rvalid) begin
                m_axi_rready <= 1'b0;
                word_valid   <= 1'b1;
            end else if (word_taken) begin
                word_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_axi_rready && m_axi_rvalid) begin
            word <= m_axi_rdata;
        end
    end

endmodule

// File: rtl/pixel_streamer.sv
/* Splits a framebuffer word into RGB565 bytes, high byte of each pixel first */
module pixel_streamer (
    input  logic               clk,
    input  logic               rst_n,
    input  lcd_pkg::fb_word_u  word,
    input  logic               word_valid,
    input  logic               pix_ready,
    output logic               pix_valid,
    output lcd_pkg::lcd_byte_t pix_byte,
    output logic               word_taken
);
    logic [1:0] byte_sel;

    // Select order 0..3 maps to bytes 1, 0, 3, 2
    assign pix_valid  = word_valid;
    assign pix_byte   = '{is_data: 1'b1, data: word.bytes[byte_sel ^ 2'b01]};
    assign word_taken = word_valid && pix_ready && (byte_sel == 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_sel <= 2'd0;
        end else if (word_valid && pix_ready) begin
            byte_sel <= byte_sel + 2'd1;
        end
    end

endmodule

// File: rtl/lcd_ctrl.sv
/* Main sequencer. Panel reset, init table, window setup and frame streaming,
   plus chip select */
module lcd_ctrl #(
    parameter int CLK_HZ = 50_000_000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,
    input  logic               frame_start,
    input  lcd_pkg::lcd_byte_t seq_byte,
    input  logic               tx_busy,
    input  logic               fetch_done,
    input  logic               pix_valid,
    input  lcd_pkg::lcd_byte_t pix_byte,
    output lcd_pkg::seq_idx_t  seq_idx,
    output logic               tx_start,
    output lcd_pkg::lcd_byte_t tx_byte,
    output logic               frame_begin,
    output logic               pix_ready,
    output logic               busy,
    output logic               frame_done,
    output logic               lcd_cs_n,
    output logic               lcd_rst_n
);
    import lcd_pkg::*;

    localparam int RST_CYC   = CLK_HZ / 5;
    localparam int SLEEP_CYC = int'(longint'(CLK_HZ) * 120 / 1000);

    typedef enum logic [2:0] {
        ST_RST_LOW,
        ST_RST_WAIT,
        ST_INIT,
        ST_SLEEP,
        ST_WINDOW,
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t      state;
    logic [31:0] delay_cnt;
    logic        framing;        // Set once the first frame has been accepted
    logic        seq_send;

    // ------------------------------
    // Byte source select
    // ------------------------------
    assign seq_send = !tx_busy && (state == ST_INIT ||
                      (state == ST_WINDOW && seq_idx != seq_idx_t'(SEQ_LEN)));
    assign pix_ready   = (state == ST_STREAM) && !tx_busy;
    assign tx_start    = seq_send || (pix_ready && pix_valid);
    assign tx_byte     = (state == ST_STREAM) ? pix_byte : seq_byte;
    assign frame_begin = (state == ST_IDLE) && frame_start && enable;
    assign busy        = (state != ST_IDLE);
    assign lcd_cs_n    = !(tx_busy || state == ST_INIT || state == ST_WINDOW ||
                           state == ST_STREAM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_RST_LOW;
            delay_cnt  <= 32'(RST_CYC - 1);
            seq_idx    <= '0;
            framing    <= 1'b0;
            frame_done <= 1'b0;
            lcd_rst_n  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (delay_cnt != '0) begin
                delay_cnt <= delay_cnt - 32'd1;    // Shared delay timer
            end
            if (seq_send) begin
                seq_idx <= seq_idx + 1'b1;
            end

            case (state)
                ST_RST_LOW: if (delay_cnt == '0) begin
                    lcd_rst_n <= 1'b1;
                    delay_cnt <= 32'(RST_CYC - 1);
                    state     <= ST_RST_WAIT;
                end
                ST_RST_WAIT: if (delay_cnt == '0) state <= ST_INIT;
                ST_INIT: if (seq_send) begin
                    if (!seq_byte.is_data && seq_byte.data == CMD_SLPOUT) begin
                        delay_cnt <= 32'(SLEEP_CYC - 1);
                        state     <= ST_SLEEP;
                    end else if (seq_idx == seq_idx_t'(INIT_LEN - 1)) begin
                        state <= ST_WINDOW;
                    end
                end
                ST_SLEEP: if (delay_cnt == '0) state <= ST_INIT;
                // Leave once RAMWR has been shifted out
                ST_WINDOW: if (!tx_busy && seq_idx == seq_idx_t'(SEQ_LEN)) begin
                    state <= framing ? ST_STREAM : ST_IDLE;
                end
                ST_IDLE: if (frame_begin) begin
                    seq_idx <= seq_idx_t'(INIT_LEN);
                    framing <= 1'b1;
                    state   <= ST_WINDOW;
                end
                ST_STREAM: if (fetch_done && !tx_busy) begin
                    frame_done <= 1'b1;
                    state      <= ST_IDLE;
                end
                default: state <= ST_RST_LOW;
            endcase
        end
    end

endmodule

// File: rtl/lcd_spi_axi.sv
/* ST7735S framebuffer driver top. AXI4 read master in, 4-wire SPI panel out */
module lcd_spi_axi #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int SPI_HZ    = 12_000_000,
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 80
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              enable,
    input  logic                              frame_start,
    input  lcd_pkg::fb_addr_t                 fb_base,
    output logic                              busy,
    output logic                              frame_done,
    // AXI4 read master
    output lcd_pkg::fb_addr_t                 m_axi_araddr,
    output logic [7:0]                        m_axi_arlen,
    output logic [2:0]                        m_axi_arsize,
    output logic [1:0]                        m_axi_arburst,
    output logic                              m_axi_arvalid,
    input  logic                              m_axi_arready,
    input  logic [lcd_pkg::AXI_DATA_BITS-1:0] m_axi_rdata,
    input  logic                              m_axi_rvalid,
    output logic                              m_axi_rready,
    // Panel pins
    output logic                              lcd_cs_n,
    output logic                              lcd_sclk,
    output logic                              lcd_mosi,
    output logic                              lcd_dc,
    output logic                              lcd_rst_n,
    output logic                              lcd_bl
);
    import lcd_pkg::*;

    seq_idx_t  seq_idx;
    lcd_byte_t seq_byte;
    lcd_byte_t tx_byte;
    lcd_byte_t pix_byte;
    fb_word_u  word;
    logic      tx_start;
    logic      tx_busy;
    logic      frame_begin;
    logic      fetch_done;
    logic      word_valid;
    logic      word_taken;
    logic      pix_valid;
    logic      pix_ready;

    assign lcd_bl = 1'b1;          // Backlight always on

    lcd_ctrl #(.CLK_HZ(CLK_HZ)) u_lcd_ctrl (
        .clk(clk), .rst_n(rst_n), .enable(enable), .frame_start(frame_start),
        .seq_byte(seq_byte), .tx_busy(tx_busy), .fetch_done(fetch_done),
        .pix_valid(pix_valid), .pix_byte(pix_byte), .seq_idx(seq_idx),
        .tx_start(tx_start), .tx_byte(tx_byte), .frame_begin(frame_begin),
        .pix_ready(pix_ready), .busy(busy), .frame_done(frame_done),
        .lcd_cs_n(lcd_cs_n), .lcd_rst_n(lcd_rst_n)
    );

    lcd_seq_rom #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_lcd_seq_rom (
        .seq_idx(seq_idx), .seq_byte(seq_byte)
    );

    spi_byte_tx #(.CLK_HZ(CLK_HZ), .SPI_HZ(SPI_HZ)) u_spi_byte_tx (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_busy(tx_busy), .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc)
    );

    fb_reader #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_fb_reader (
        .clk(clk), .rst_n(rst_n), .frame_begin(frame_begin), .fb_base(fb_base),
        .word_taken(word_taken), .m_axi_arready(m_axi_arready),
        .m_axi_rdata(m_axi_rdata), .m_axi_rvalid(m_axi_rvalid), .word(word),
        .word_valid(word_valid), .fetch_done(fetch_done), .m_axi_araddr(m_axi_araddr),
        .m_axi_arlen(m_axi_arlen), .m_axi_arsize(m_axi_arsize),
        .m_axi_arburst(m_axi_arburst), .m_axi_arvalid(m_axi_arvalid),
        .m_axi_rready(m_axi_rready)
    );

    pixel_streamer u_pixel_streamer (
        .clk(clk), .rst_n(rst_n), .word(word), .word_valid(word_valid),
        .pix_ready(pix_ready), .pix_valid(pix_valid), .pix_byte(pix_byte),
        .word_taken(word_taken)
    );

endmodule

// File: include/tb_models.svh
/* Testbench models. LFSR, AXI memory responder and SPI byte capture */
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// Fibonacci LFSR with taps 16 14 13 11. One step per bit drawn
function automatic int unsigned lfsr_take(input int nbits);
    int unsigned v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        v    = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

// Fixed memory contents as a function of the byte address
function automatic logic [31:0] addr_hash(input lcd_pkg::fb_addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
endfunction

// Single-beat AXI read slave with 0..3 cycles of random stall per channel
task automatic axi_mem_responder();
    lcd_pkg::fb_addr_t addr;
    forever begin
        m_axi_arready = 1'b0;
        m_axi_rvalid  = 1'b0;
        @(negedge clk iff m_axi_arvalid);
        repeat (lfsr_take(2)) @(negedge clk);
        addr          = m_axi_araddr;
        m_axi_arready = 1'b1;
        @(negedge clk);
        m_axi_arready = 1'b0;
        addr_q.push_back(addr);
        repeat (lfsr_take(2)) @(negedge clk);
        m_axi_rdata  = addr_hash(addr);
        m_axi_rvalid = 1'b1;
        @(posedge clk iff m_axi_rready);
        @(negedge clk);
    end
endtask

// Samples mosi and dc on each rising sclk edge, eight bits per byte
task automatic spi_capture();
    lcd_pkg::lcd_byte_t b;
    forever begin
        b = '0;
        repeat (8) begin
            @(posedge lcd_sclk);
            b.data    = {b.data[6:0], lcd_mosi};
            b.is_data = lcd_dc;
        end
        cap_q.push_back(b);
    end
endtask

`endif

// File: test/tb_lcd_spi_axi.sv
/* Testbench for the LCD framebuffer SPI driver. Random AXI stalls and bases,
   SPI bytes checked against a model queue */
module tb_lcd_spi_axi;
    import lcd_pkg::*;

    localparam int CLK_HZ    = 1000;
    localparam int SPI_HZ    = 250;
    localparam int FB_WIDTH  = 8;
    localparam int FB_HEIGHT = 4;
    localparam int FB_WORDS  = FB_WIDTH * FB_HEIGHT / 2;
    localparam int SPI_DIV   = CLK_HZ / (2 * SPI_HZ);
    localparam int FRAMES    = 6;
    localparam int RUN_BYTES = SEQ_LEN + FRAMES * (WIN_LEN + 2 * FB_WIDTH * FB_HEIGHT);
    localparam int WATCH_CYC = 2 * (CLK_HZ / 5) + CLK_HZ * 120 / 1000 +
                               RUN_BYTES * (16 * SPI_DIV + 2) + FRAMES * FB_WORDS * 8 + 2000;

    logic        clk = 1'b0;
    logic        rst_n, enable, frame_start;
    fb_addr_t    fb_base;
    logic        busy, frame_done;
    fb_addr_t    m_axi_araddr;
    logic [7:0]  m_axi_arlen;
    logic [2:0]  m_axi_arsize;
    logic [1:0]  m_axi_arburst;
    logic        m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready;
    logic [31:0] m_axi_rdata;
    logic        lcd_cs_n, lcd_sclk, lcd_mosi, lcd_dc, lcd_rst_n, lcd_bl;

    logic [15:0] lfsr = 16'd49337;
    lcd_byte_t   cap_q[$];
    lcd_byte_t   exp_q[$];
    fb_addr_t    addr_q[$];
    fb_addr_t    exp_addr_q[$];
    int          done_count = 0;

    `include "tb_models.svh"

    always #4 clk = ~clk;

    lcd_spi_axi #(
        .CLK_HZ(CLK_HZ), .SPI_HZ(SPI_HZ), .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) u_lcd_spi_axi (
        .clk(clk), .rst_n(rst_n), .enable(enable), .frame_start(frame_start),
        .fb_base(fb_base), .busy(busy), .frame_done(frame_done),
        .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen), .m_axi_arsize(m_axi_arsize),
        .m_axi_arburst(m_axi_arburst), .m_axi_arvalid(m_axi_arvalid),
        .m_axi_arready(m_axi_arready), .m_axi_rdata(m_axi_rdata),
        .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready),
        .lcd_cs_n(lcd_cs_n), .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc),
        .lcd_rst_n(lcd_rst_n), .lcd_bl(lcd_bl)
    );

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input lcd_byte_t exp, input lcd_byte_t act);
        if (exp !== act) begin
            stop_with_failure($sformatf("Error %s: expected dc=%0b data=0x%02h, actual dc=%0b data=0x%02h",
                                        name, exp.is_data, exp.data, act.is_data, act.data));
        end
    endtask

    task automatic check_addr(input string name, input fb_addr_t exp, input fb_addr_t act);
        if (exp !== act) begin
            stop_with_failure($sformatf("Error %s: expected 0x%08h, actual 0x%08h",
                                        name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_failure($sformatf("Error %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic check_attr(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            stop_with_failure($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Pin rules that hold at every cycle
    always @(negedge clk) begin
        if (frame_done) begin
            done_count++;
            check_bit("busy with frame_done", 1'b0, busy);
        end
        if (lcd_sclk) begin
            check_bit("lcd_rst_n before sclk", 1'b1, lcd_rst_n);
            check_bit("lcd_cs_n while clocking", 1'b0, lcd_cs_n);
        end
        if (m_axi_arvalid) begin
            check_attr("arlen", 8'd0, m_axi_arlen);
            check_attr("arsize", 8'd2, 8'(m_axi_arsize));
            check_attr("arburst", 8'd1, 8'(m_axi_arburst));
        end
    end

    task automatic compare_streams(input string name);
        lcd_byte_t exp_b;
        lcd_byte_t act_b;
        if (cap_q.size() != exp_q.size()) begin
            stop_with_failure($sformatf("Error %s: expected %0d SPI bytes, actual %0d",
                                        name, exp_q.size(), cap_q.size()));
        end
        while (exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            act_b = cap_q.pop_front();
            check_byte(name, exp_b, act_b);
        end
    endtask

    task automatic compare_addrs(input string name);
        fb_addr_t exp_a;
        fb_addr_t act_a;
        if (addr_q.size() != exp_addr_q.size()) begin
            stop_with_failure($sformatf("Error %s: expected %0d AXI reads, actual %0d",
                                        name, exp_addr_q.size(), addr_q.size()));
        end
        while (exp_addr_q.size() > 0) begin
            exp_a = exp_addr_q.pop_front();
            act_a = addr_q.pop_front();
            check_addr(name, exp_a, act_a);
        end
    endtask

    // ------------------------------
    // Model
    // ------------------------------
    task automatic push_expected(input logic is_data, input logic [7:0] data);
        lcd_byte_t b;
        b.is_data = is_data;
        b.data    = data;
        exp_q.push_back(b);
    endtask

    task automatic push_window();
        push_expected(1'b0, CMD_CASET);
        push_expected(1'b1, 8'h00);
        push_expected(1'b1, 8'(WIN_X_START));
        push_expected(1'b1, 8'(FB_WIDTH >> 8));
        push_expected(1'b1, 8'(FB_WIDTH));
        push_expected(1'b0, CMD_RASET);
        push_expected(1'b1, 8'h00);
        push_expected(1'b1, 8'(WIN_Y_START));
        push_expected(1'b1, 8'((FB_HEIGHT + WIN_Y_START - 1) >> 8));
        push_expected(1'b1, 8'(FB_HEIGHT + WIN_Y_START - 1));
        push_expected(1'b0, CMD_RAMWR);
    endtask

    // High byte then low byte, pixel 0 first
    task automatic push_frame(input fb_addr_t base);
        fb_addr_t a;
        fb_word_u w;
        for (int i = 0; i < FB_WORDS; i++) begin
            a = base + fb_addr_t'(4 * i);
            exp_addr_q.push_back(a);
            w = addr_hash(a);
            for (int p = 0; p < 2; p++) begin
                push_expected(1'b1, w.pix[p][15:8]);
                push_expected(1'b1, w.pix[p][7:0]);
            end
        end
    endtask

    function automatic fb_addr_t random_base();
        return fb_addr_t'(lfsr_take(30)) << 2;
    endfunction

    // One frame; a second start arrives after poke_after cycles when nonzero
    task automatic run_frame(input string name, input fb_addr_t base, input int poke_after);
        push_window();
        push_frame(base);
        fb_base     = base;
        enable      = 1'b1;
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        check_bit({name, " busy"}, 1'b1, busy);
        if (poke_after > 0) begin
            repeat (poke_after) @(negedge clk);
            fb_base     = random_base();
            frame_start = 1'b1;
            @(negedge clk);
            frame_start = 1'b0;
            check_bit({name, " busy after extra start"}, 1'b1, busy);
        end
        @(negedge clk iff frame_done);
        @(negedge clk);
        check_bit({name, " frame_done width"}, 1'b0, frame_done);
        check_bit({name, " busy after done"}, 1'b0, busy);
        compare_streams(name);
        compare_addrs(name);
    endtask

    initial begin
        rst_n         = 1'b0;
        enable        = 1'b0;
        frame_start   = 1'b0;
        fb_base       = '0;
        m_axi_arready = 1'b0;
        m_axi_rvalid  = 1'b0;
        m_axi_rdata   = '0;
        fork
            axi_mem_responder();
            spi_capture();
        join_none

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset busy", 1'b1, busy);
        check_bit("reset lcd_rst_n", 1'b0, lcd_rst_n);
        check_bit("reset lcd_cs_n", 1'b1, lcd_cs_n);
        check_bit("reset lcd_sclk", 1'b0, lcd_sclk);
        check_bit("reset arvalid", 1'b0, m_axi_arvalid);
        check_bit("reset rready", 1'b0, m_axi_rready);
        check_bit("reset frame_done", 1'b0, frame_done);
        check_bit("backlight", 1'b1, lcd_bl);

        // Power-on init and window
        foreach (INIT_TABLE[i]) begin
            exp_q.push_back(INIT_TABLE[i]);
        end
        push_window();
        @(negedge clk iff !busy);
        compare_streams("init");
        compare_addrs("init");

        run_frame("frame", random_base(), 0);
        for (int f = 0; f < 4; f++) begin
            run_frame($sformatf("stall_frame%0d", f), random_base(), 0);
        end

        // Start with enable low is dropped
        enable      = 1'b0;
        fb_base     = random_base();
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        check_bit("disabled start busy", 1'b0, busy);
        repeat (40) @(negedge clk);
        check_bit("disabled start busy later", 1'b0, busy);
        compare_streams("disabled start");
        compare_addrs("disabled start");

        run_frame("busy_start", random_base(), 20);
        repeat (40) @(negedge clk);
        check_bit("busy_start idle", 1'b0, busy);
        compare_streams("busy_start idle");
        compare_addrs("busy_start idle");

        if (done_count == FRAMES) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure($sformatf("Error frame_done count: expected %0d, actual %0d",
                                        FRAMES, done_count));
        end
    end

    initial begin
        #(WATCH_CYC * 8);
        stop_with_failure("Watchdog timeout: the DUT did not finish the tests in time");
    end

endmodule

// File: files.f
+incdir+include
rtl/lcd_pkg.sv
rtl/lcd_seq_rom.sv
rtl/spi_byte_tx.sv
rtl/fb_reader.sv
rtl/pixel_streamer.sv
rtl/lcd_ctrl.sv
rtl/lcd_spi_axi.sv
test/tb_lcd_spi_axi.sv
